/* hdl/icmp_pkg.sv */
`default_nettype none

package icmp_pkg;

    // ============================================================
    // field widths
    // ============================================================
    localparam int IP_ADDR_W = 32;
    localparam int IP_LEN_W  = 16;

    // ============================================================
    // protocol values
    // ============================================================
    localparam logic [7:0] ICMP_PROTO        = 8'd1;
    localparam logic [7:0] ICMP_ECHO_REQUEST = 8'd8;
    localparam logic [7:0] ICMP_ECHO_REPLY   = 8'd0;

    // request type minus reply type lands in the checksum high byte
    localparam logic [7:0] CSUM_DELTA        = 8'd8;

endpackage

`default_nettype wire

/* hdl/icmp_job_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface icmp_job_if
    import icmp_pkg::*;
();

    logic                 job_valid;         // a frame is the current job
    logic                 drop;              // meaningful only with job_valid
    logic [IP_ADDR_W-1:0] reply_source_ip;
    logic [IP_ADDR_W-1:0] reply_dest_ip;
    logic [IP_LEN_W-1:0]  reply_length;
    logic                 hdr_sent;          // reply header handshake
    logic                 frame_done;        // last payload beat of the job

    modport decode (
        output job_valid, drop, reply_source_ip, reply_dest_ip, reply_length,
        input  frame_done
    );

    modport header (
        input  job_valid, drop, reply_source_ip, reply_dest_ip, reply_length,
        output hdr_sent
    );

    modport payload (
        input  job_valid, drop, hdr_sent,
        output frame_done
    );

endinterface

`default_nettype wire

/* hdl/icmp_frame_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_frame_decode
    import icmp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 s_ip_hdr_valid,
    output logic                 s_ip_hdr_ready,
    input  logic [IP_LEN_W-1:0]  s_ip_length,
    input  logic [7:0]           s_ip_protocol,
    input  logic [IP_ADDR_W-1:0] s_ip_source_ip,
    input  logic [IP_ADDR_W-1:0] s_ip_dest_ip,
    input  logic [7:0]           s_payload_tdata,
    input  logic                 s_payload_tvalid,
    input  logic [IP_ADDR_W-1:0] local_ip,
    icmp_job_if.decode           job
);

    logic decide;
    logic is_echo;

    // the first payload byte is only looked at here, the payload unit consumes it later
    assign decide  = !job.job_valid && s_ip_hdr_valid && s_payload_tvalid;
    assign is_echo = (s_ip_protocol == ICMP_PROTO) &&
                     (s_ip_dest_ip == local_ip) &&
                     (s_payload_tdata == ICMP_ECHO_REQUEST);

    // ============================================================
    // job control
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            job.job_valid  <= 1'b0;
            s_ip_hdr_ready <= 1'b0;
        end
        else
        begin
            s_ip_hdr_ready <= decide;              // one-cycle acceptance pulse
            if (decide)
                job.job_valid <= 1'b1;
            else if (job.frame_done)
                job.job_valid <= 1'b0;             // idle for one cycle between frames
        end
    end

    // ============================================================
    // job fields, held until frame_done
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (decide)
        begin
            job.drop            <= !is_echo;
            job.reply_source_ip <= s_ip_dest_ip;   // addresses swapped for the reply
            job.reply_dest_ip   <= s_ip_source_ip;
            job.reply_length    <= s_ip_length;
        end
    end

    // a frame may only end as the current job, so the next decision sees a fresh first byte
    assert property (@(posedge clk) disable iff (rst)
        job.frame_done |-> job.job_valid)
        else $error("a frame ended while no job was active");

endmodule

`default_nettype wire

/* hdl/icmp_reply_header.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_reply_header
    import icmp_pkg::*;
#(
    parameter logic [7:0] REPLY_TTL  = 8'd64,
    parameter logic [5:0] REPLY_DSCP = 6'd0
)
(
    input  logic                 clk,
    input  logic                 rst,
    output logic                 m_ip_hdr_valid,
    input  logic                 m_ip_hdr_ready,
    output logic [IP_LEN_W-1:0]  m_ip_length,
    output logic [5:0]           m_ip_dscp,
    output logic [1:0]           m_ip_ecn,
    output logic [7:0]           m_ip_ttl,
    output logic [7:0]           m_ip_protocol,
    output logic [IP_ADDR_W-1:0] m_ip_source_ip,
    output logic [IP_ADDR_W-1:0] m_ip_dest_ip,
    icmp_job_if.header           job
);

    logic hdr_done;    // header of the current job already went out

    assign job.hdr_sent = m_ip_hdr_valid && m_ip_hdr_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            m_ip_hdr_valid <= 1'b0;
            hdr_done       <= 1'b0;
        end
        else
        begin
            if (!job.job_valid)
                hdr_done <= 1'b0;
            if (job.hdr_sent)
            begin
                m_ip_hdr_valid <= 1'b0;
                hdr_done       <= 1'b1;
            end
            else if (job.job_valid && !job.drop && !hdr_done)
                m_ip_hdr_valid <= 1'b1;            // once per reply job
        end
    end

    assign m_ip_length    = job.reply_length;
    assign m_ip_dscp      = REPLY_DSCP;
    assign m_ip_ecn       = 2'b00;
    assign m_ip_ttl       = REPLY_TTL;
    assign m_ip_protocol  = ICMP_PROTO;
    assign m_ip_source_ip = job.reply_source_ip;
    assign m_ip_dest_ip   = job.reply_dest_ip;

    // the decode unit must hold the job fields while the header is stalled
    assert property (@(posedge clk) disable iff (rst)
        m_ip_hdr_valid && !m_ip_hdr_ready |=> m_ip_hdr_valid &&
            $stable(m_ip_length) && $stable(m_ip_source_ip) && $stable(m_ip_dest_ip))
        else $error("reply header changed while stalled");

endmodule

`default_nettype wire

/* hdl/icmp_payload_rewrite.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_payload_rewrite
    import icmp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  s_payload_tdata,
    input  logic        s_payload_tvalid,
    output logic        s_payload_tready,
    input  logic        s_payload_tlast,
    output logic [7:0]  m_payload_tdata,
    output logic        m_payload_tvalid,
    input  logic        m_payload_tready,
    output logic        m_payload_tlast,
    icmp_job_if.payload job
);

    logic       fwd;          // reply payload is being forwarded
    logic       drop_mode;
    logic       beat;
    logic [2:0] beat_cnt;     // sticks at 4, only bytes 0 to 3 matter
    logic [8:0] csum_hi;
    logic       csum_carry;

    assign drop_mode = job.job_valid && job.drop;

    // ============================================================
    // stream handshake
    // ============================================================
    assign m_payload_tvalid = fwd && s_payload_tvalid;
    assign m_payload_tlast  = fwd && s_payload_tlast;
    assign s_payload_tready = drop_mode || (fwd && m_payload_tready);
    assign beat             = s_payload_tvalid && s_payload_tready;
    assign job.frame_done   = beat && s_payload_tlast;

    always_ff @(posedge clk)
    begin
        if (rst)
            fwd <= 1'b0;
        else if (job.hdr_sent)
            fwd <= 1'b1;
        else if (fwd && job.frame_done)
            fwd <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            beat_cnt <= 3'd0;
        else if (fwd && beat)
        begin
            if (s_payload_tlast)
                beat_cnt <= 3'd0;                  // ready for the next reply
            else if (beat_cnt != 3'd4)
                beat_cnt <= beat_cnt + 3'd1;
        end
    end

    // ============================================================
    // type and checksum rewrite
    // ============================================================
    assign csum_hi = {1'b0, s_payload_tdata} + {1'b0, CSUM_DELTA};

    // the carry out of the high byte wraps into the low byte
    always_ff @(posedge clk)
    begin
        if (fwd && beat && beat_cnt == 3'd2)
            csum_carry <= csum_hi[8];
    end

    always_comb
    begin
        case (beat_cnt)
            3'd0:    m_payload_tdata = ICMP_ECHO_REPLY;
            3'd2:    m_payload_tdata = csum_hi[7:0];
            3'd3:    m_payload_tdata = s_payload_tdata + {7'd0, csum_carry};
            default: m_payload_tdata = s_payload_tdata;
        endcase
    end

    // forwarding starts only on a header handshake, which a dropped job never gets
    assert property (@(posedge clk) disable iff (rst)
        job.drop |-> !m_payload_tvalid)
        else $error("payload forwarded for a dropped frame");

endmodule

`default_nettype wire

/* hdl/icmp_echo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_top
    import icmp_pkg::*;
#(
    parameter logic [7:0] REPLY_TTL  = 8'd64,
    parameter logic [5:0] REPLY_DSCP = 6'd0
)
(
    input  logic                 clk,
    input  logic                 rst,
    // ============================================================
    // IP frame input
    // ============================================================
    input  logic                 s_ip_hdr_valid,
    output logic                 s_ip_hdr_ready,
    input  logic [IP_LEN_W-1:0]  s_ip_length,
    input  logic [7:0]           s_ip_protocol,
    input  logic [IP_ADDR_W-1:0] s_ip_source_ip,
    input  logic [IP_ADDR_W-1:0] s_ip_dest_ip,
    input  logic [7:0]           s_payload_tdata,
    input  logic                 s_payload_tvalid,
    output logic                 s_payload_tready,
    input  logic                 s_payload_tlast,
    // ============================================================
    // echo reply output
    // ============================================================
    output logic                 m_ip_hdr_valid,
    input  logic                 m_ip_hdr_ready,
    output logic [IP_LEN_W-1:0]  m_ip_length,
    output logic [5:0]           m_ip_dscp,
    output logic [1:0]           m_ip_ecn,
    output logic [7:0]           m_ip_ttl,
    output logic [7:0]           m_ip_protocol,
    output logic [IP_ADDR_W-1:0] m_ip_source_ip,
    output logic [IP_ADDR_W-1:0] m_ip_dest_ip,
    output logic [7:0]           m_payload_tdata,
    output logic                 m_payload_tvalid,
    input  logic                 m_payload_tready,
    output logic                 m_payload_tlast,
    input  logic [IP_ADDR_W-1:0] local_ip
);

    icmp_job_if job_if ();

    icmp_frame_decode icmp_frame_decode_inst (
        .clk              (clk),
        .rst              (rst),
        .s_ip_hdr_valid   (s_ip_hdr_valid),
        .s_ip_hdr_ready   (s_ip_hdr_ready),
        .s_ip_length      (s_ip_length),
        .s_ip_protocol    (s_ip_protocol),
        .s_ip_source_ip   (s_ip_source_ip),
        .s_ip_dest_ip     (s_ip_dest_ip),
        .s_payload_tdata  (s_payload_tdata),
        .s_payload_tvalid (s_payload_tvalid),
        .local_ip         (local_ip),
        .job              (job_if.decode)
    );

    icmp_reply_header #(
        .REPLY_TTL  (REPLY_TTL),
        .REPLY_DSCP (REPLY_DSCP)
    ) icmp_reply_header_inst (
        .clk            (clk),
        .rst            (rst),
        .m_ip_hdr_valid (m_ip_hdr_valid),
        .m_ip_hdr_ready (m_ip_hdr_ready),
        .m_ip_length    (m_ip_length),
        .m_ip_dscp      (m_ip_dscp),
        .m_ip_ecn       (m_ip_ecn),
        .m_ip_ttl       (m_ip_ttl),
        .m_ip_protocol  (m_ip_protocol),
        .m_ip_source_ip (m_ip_source_ip),
        .m_ip_dest_ip   (m_ip_dest_ip),
        .job            (job_if.header)
    );

    icmp_payload_rewrite icmp_payload_rewrite_inst (
        .clk              (clk),
        .rst              (rst),
        .s_payload_tdata  (s_payload_tdata),
        .s_payload_tvalid (s_payload_tvalid),
        .s_payload_tready (s_payload_tready),
        .s_payload_tlast  (s_payload_tlast),
        .m_payload_tdata  (m_payload_tdata),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tready (m_payload_tready),
        .m_payload_tlast  (m_payload_tlast),
        .job              (job_if.payload)
    );

endmodule

`default_nettype wire

/* verif/tb_icmp_echo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icmp_echo
    import icmp_pkg::*;
();

    localparam logic [7:0]  REPLY_TTL  = 8'd100;
    localparam logic [5:0]  REPLY_DSCP = 6'd46;
    localparam logic [31:0] LOCAL_IP   = 32'hc0a8_0105;
    localparam int          FRAMES     = 60;
    localparam int          TIMEOUT    = 1000;    // cycles allowed for each wait loop

    logic                 clk, rst;
    logic                 s_ip_hdr_valid, s_ip_hdr_ready, m_ip_hdr_valid, m_ip_hdr_ready;
    logic [IP_LEN_W-1:0]  s_ip_length, m_ip_length;
    logic [7:0]           s_ip_protocol, m_ip_protocol, m_ip_ttl;
    logic [IP_ADDR_W-1:0] s_ip_source_ip, s_ip_dest_ip, m_ip_source_ip, m_ip_dest_ip;
    logic [IP_ADDR_W-1:0] local_ip;
    logic [5:0]           m_ip_dscp;
    logic [1:0]           m_ip_ecn;
    logic [7:0]           s_payload_tdata, m_payload_tdata;
    logic                 s_payload_tvalid, s_payload_tready, s_payload_tlast;
    logic                 m_payload_tvalid, m_payload_tready, m_payload_tlast;

    logic [31:0] rng_state = 32'd41;
    logic [15:0] exp_len_q [$];               // model of every reply, in order
    logic [31:0] exp_src_q [$];
    logic [31:0] exp_dst_q [$];
    logic [7:0]  exp_byte_q [$];
    logic        exp_last_q [$];
    logic [7:0]  next_bytes [0:63];           // payload of the frame whose header is up
    int          next_len = 0;
    int          hdr_idx = 0;                 // next expected header for the monitor
    int          byte_idx = 0;
    logic        in_reply = 1'b0;
    int          hdr_pulses = 0;
    int          expected_replies = 0;

    icmp_echo_top #(
        .REPLY_TTL  (REPLY_TTL),
        .REPLY_DSCP (REPLY_DSCP)
    ) icmp_echo_top_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ============================================================
    // stimulus and reference model
    // ============================================================
    task automatic present_frame();
        logic [31:0] r;
        logic [8:0]  csum_hi;
        logic        reply;
        int          idx;

        r = xorshift32();
        next_len = 8 + int'(r[31:16]) % 33;
        s_ip_protocol  = (r[1:0] != 2'd0) ? ICMP_PROTO : 8'd17;
        s_ip_source_ip = xorshift32();
        s_ip_dest_ip   = (r[3:2] != 2'd0) ? LOCAL_IP : xorshift32();
        s_ip_length    = 16'(next_len + 20);
        next_bytes[0]  = (r[5:4] != 2'd0) ? ICMP_ECHO_REQUEST : (r[15:8] | 8'h10);
        for (idx = 1; idx < next_len; idx++)
        begin
            r = xorshift32();
            next_bytes[idx] = r[7:0];
        end

        reply = (s_ip_protocol == 8'd1) && (s_ip_dest_ip == LOCAL_IP) &&
                (next_bytes[0] == 8'd8);
        if (reply)
        begin
            expected_replies++;
            exp_len_q.push_back(s_ip_length);
            exp_src_q.push_back(s_ip_dest_ip);
            exp_dst_q.push_back(s_ip_source_ip);
            // type 8 to 0 raises the ones' complement sum by 8 in the high byte
            csum_hi = {1'b0, next_bytes[2]} + 9'd8;
            for (idx = 0; idx < next_len; idx++)
            begin
                if (idx == 0)
                    exp_byte_q.push_back(8'h00);
                else if (idx == 2)
                    exp_byte_q.push_back(csum_hi[7:0]);
                else if (idx == 3)
                    exp_byte_q.push_back(next_bytes[3] + {7'd0, csum_hi[8]});
                else
                    exp_byte_q.push_back(next_bytes[idx]);
                exp_last_q.push_back(idx == next_len - 1);
            end
        end
        s_ip_hdr_valid = 1'b1;
    endtask

    task automatic stream_payload(input logic more);
        logic [7:0]  frame_bytes [0:63];
        logic [31:0] r;
        logic        hdr_taken;
        logic        accepted;
        logic        next_up;
        int          len;
        int          idx;
        int          wait_cycles;

        frame_bytes = next_bytes;
        len = next_len;
        hdr_taken = 1'b0;
        accepted = 1'b1;
        next_up = 1'b0;
        idx = 0;
        wait_cycles = 0;
        while (idx < len)
        begin
            r = xorshift32();
            if (accepted || !s_payload_tvalid)
                s_payload_tvalid = (r[2:0] != 3'd0);   // a pending byte is never withdrawn
            s_payload_tdata  = frame_bytes[idx];
            s_payload_tlast  = (idx == len - 1);
            m_ip_hdr_ready   = (r[4:3] != 2'd0);
            m_payload_tready = (r[6:5] != 2'd0);
            @(posedge clk);
            accepted = s_payload_tvalid && s_payload_tready;
            if (s_ip_hdr_ready && hdr_taken)
                abort_run("s_ip_hdr_ready pulsed again before the frame's last beat");
            else if (accepted && !hdr_taken && !s_ip_hdr_ready)
                abort_run("a payload byte was consumed before its header was accepted");
            else if (wait_cycles == TIMEOUT)
                abort_run("the frame payload was not consumed in time");
            else
            begin
                hdr_taken = hdr_taken || s_ip_hdr_ready;
                if (accepted)
                    idx++;
                wait_cycles++;
            end
            @(negedge clk);
            if (hdr_taken && !next_up)
                s_ip_hdr_valid = 1'b0;
            if (more && hdr_taken && !next_up && r[7])
            begin
                present_frame();                   // next header waits behind this frame
                next_up = 1'b1;
            end
        end
        if (more && !next_up)
            present_frame();
    endtask

    // ============================================================
    // output monitor
    // ============================================================
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (s_ip_hdr_ready)
                hdr_pulses++;
            if (m_ip_hdr_valid && m_ip_hdr_ready)
            begin
                if (in_reply || hdr_idx >= exp_len_q.size())
                    abort_run("a reply header appeared where none was expected");
                else
                begin
                    check_value("m_ip_length", 32'(m_ip_length), 32'(exp_len_q[hdr_idx]));
                    check_value("m_ip_source_ip", m_ip_source_ip, exp_src_q[hdr_idx]);
                    check_value("m_ip_dest_ip", m_ip_dest_ip, exp_dst_q[hdr_idx]);
                    check_value("m_ip_protocol", 32'(m_ip_protocol), 32'd1);
                    check_value("m_ip_ttl", 32'(m_ip_ttl), 32'(REPLY_TTL));
                    check_value("m_ip_dscp", 32'(m_ip_dscp), 32'(REPLY_DSCP));
                    check_value("m_ip_ecn", 32'(m_ip_ecn), 32'd0);
                    hdr_idx++;
                    in_reply = 1'b1;
                end
            end
            if (m_payload_tvalid && m_payload_tready)
            begin
                if (!in_reply || byte_idx >= exp_byte_q.size())
                    abort_run("a payload byte left the DUT outside a reply");
                else
                begin
                    check_value("m_payload_tdata", 32'(m_payload_tdata),
                                32'(exp_byte_q[byte_idx]));
                    check_value("m_payload_tlast", 32'(m_payload_tlast),
                                32'(exp_last_q[byte_idx]));
                    byte_idx++;
                    if (m_payload_tlast)
                        in_reply = 1'b0;
                end
            end
        end
    end

    initial
    begin
        int wait_cycles;
        rst = 1'b1;
        s_ip_hdr_valid = 1'b0;
        s_ip_length = '0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_payload_tdata = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
        m_ip_hdr_ready = 1'b0;
        m_payload_tready = 1'b0;
        local_ip = LOCAL_IP;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        present_frame();
        for (int f = 0; f < FRAMES; f++)
            stream_payload(f < FRAMES - 1);       // frames follow back to back

        s_payload_tvalid = 1'b0;
        s_payload_tlast = 1'b0;
        m_ip_hdr_ready = 1'b1;
        m_payload_tready = 1'b1;
        wait_cycles = 0;
        while (in_reply || hdr_idx != exp_len_q.size())
        begin
            if (wait_cycles == TIMEOUT)
                abort_run("the last reply did not leave the DUT");
            else
            begin
                @(negedge clk);
                wait_cycles++;
            end
        end
        repeat (4) @(negedge clk);

        check_value("m_ip_hdr_valid replies", hdr_idx, expected_replies);
        check_value("m_payload_tvalid bytes", byte_idx, exp_byte_q.size());
        check_value("s_ip_hdr_ready pulses", hdr_pulses, FRAMES);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* icmp_echo_top.f */
hdl/icmp_pkg.sv
hdl/icmp_job_if.sv
hdl/icmp_frame_decode.sv
hdl/icmp_reply_header.sv
hdl/icmp_payload_rewrite.sv
hdl/icmp_echo_top.sv
verif/tb_icmp_echo.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_icmp_echo -f icmp_echo_top.f &&
out=$(./obj_dir/Vtb_icmp_echo 2>&1)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
